// ==== bench/parking_cases.txt ====
// Columns in hex: kind (0 park, 1 retrieve), plate, status (0 done, 1 full, 2 missing),
// floor, spot (0 left, 1 right); full and missing results report floor 0 spot 0
0 1001 0 1 0
0 8003 0 1 1
0 9005 0 3 0
0 2002 0 2 0
0 8004 0 2 1
0 9006 0 4 0
1 1001 0 1 0
0 3007 0 1 0
0 4009 0 3 1
0 500b 0 5 0
0 600d 0 5 1
0 700f 0 7 0
0 a011 0 7 1
0 b013 1 0 0
1 c015 2 0 0
0 a008 0 4 1
0 b00a 0 6 0
0 c00c 0 6 1
1 4009 0 3 1
0 d00e 0 3 1
0 e010 1 0 0
1 8003 0 1 1
1 8004 0 2 1
1 9006 0 4 0
0 f012 0 2 1
0 1015 0 1 1
1 d00e 0 3 1
1 2002 0 2 0
0 2014 0 2 0
1 700f 0 7 0
1 700f 2 0 0
0 3017 0 3 1
0 4019 0 7 0
0 501a 0 4 0

// ==== project.f ====
source/parking_pkg.sv
source/order_if.sv
source/order_intake.sv
source/order_fifo.sv
source/spot_allocator.sv
source/fee_meters.sv
source/elevator_controller.sv
source/parking_lot_top.sv
bench/tb_parking_lot.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the car park testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_parking_lot \
	-f project.f \
	--Mdir obj_dir -o tb_parking_lot

./obj_dir/tb_parking_lot | tee sim.log

if grep -qx "Test passed" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi

// ==== bench/tb_parking_lot.sv ====
/* Car park testbench */
`timescale 1ns/1ps

module tb_parking_lot;
	import parking_pkg::*;

	localparam int FLOORS = 7;
	localparam int QUEUE_DEPTH = 8;
	localparam int PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_CASES = 64;
	localparam int JOB_CYCLES = 2 * FLOORS + 4;   // Idle, lookup, trip up and down, report
	localparam int STALL_CYCLES = 16;             // Allowance for result_ready stalls

	logic clock = 1'b0;
	logic reset;
	logic order_valid;
	logic order_ready;
	order_kind_e order_kind;
	plate_t order_plate;
	logic result_valid;
	logic result_ready;
	result_status_e result_status;
	plate_t result_plate;
	floor_t result_floor;
	spot_t result_spot;
	fee_t result_fee;

	logic [15:0] case_words [0:5*MAX_CASES-1];   // kind, plate, status, floor, spot
	logic [15:0] lot [1:FLOORS][0:1];            // Reference table, 0 is empty
	int place_start [1:FLOORS][0:1];             // First report cycle of the park job
	int num_cases = 0;
	int errors = 0;
	int passed = 0;
	int failed = 0;
	int cycle_count = 0;
	logic loaded = 1'b0;
	logic [31:0] lcg_state = 32'd78;

	parking_lot_top #(.floors(FLOORS), .queue_depth(QUEUE_DEPTH)) dut (
		.clock(clock),
		.reset(reset),
		.order_valid(order_valid),
		.order_ready(order_ready),
		.order_kind(order_kind),
		.order_plate(order_plate),
		.result_valid(result_valid),
		.result_ready(result_ready),
		.result_status(result_status),
		.result_plate(result_plate),
		.result_floor(result_floor),
		.result_spot(result_spot),
		.result_fee(result_fee)
	);

	always #(PERIOD / 2) clock = ~clock;

	always @(posedge clock) cycle_count <= cycle_count + 1;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	// Top nibble 9 is exempt, 8 is hybrid, the rest pay double
	function automatic int tariff_rate(input logic [15:0] plate);
		case (plate[15:12])
			4'h9: return 0;
			4'h8: return 1;
			default: return 2;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("[FAIL] %0t ns %s expected %0h got %0h", $time, name, expected, actual);
		errors++;
	endtask

	// Holds the order until the intake takes it, returns on the following falling edge
	task automatic send_order(input logic kind, input logic [15:0] plate);
		logic taken;
		order_valid = 1'b1;
		order_kind = kind ? RETRIEVE : PARK;
		order_plate = plate;
		taken = 1'b0;
		while (!taken) begin
			taken = order_ready;
			@(negedge clock);
		end
		order_valid = 1'b0;
	endtask

	// Applies one order to the reference table and gives the expected result
	task automatic model_order(input logic kind, input logic [15:0] plate, input int start,
		output int st, output int fl, output int sp, output int fee);
		logic even_free;
		logic allowed;
		logic found;
		int n;
		st = 0;
		fl = 0;
		sp = 0;
		fee = 0;
		found = 1'b0;
		if (!kind) begin
			even_free = 1'b0;
			for (int f = 2; f <= FLOORS; f += 2) begin
				for (int s = 0; s < 2; s++) begin
					if (lot[f][s] == 16'h0)
						even_free = 1'b1;
				end
			end
			for (int f = 1; f <= FLOORS; f++) begin
				allowed = (f % 2 == 1) ? (plate[0] || !even_free) : !plate[0];
				for (int s = 0; s < 2; s++) begin
					if (!found && allowed && lot[f][s] == 16'h0) begin
						found = 1'b1;
						fl = f;
						sp = s;
					end
				end
			end
			if (found) begin
				lot[fl][sp] = plate;
				place_start[fl][sp] = start;
			end else begin
				st = 1;
			end
		end else begin
			for (int f = 1; f <= FLOORS; f++) begin
				for (int s = 0; s < 2; s++) begin
					if (!found && lot[f][s] == plate) begin
						found = 1'b1;
						fl = f;
						sp = s;
					end
				end
			end
			if (found) begin
				lot[fl][sp] = 16'h0;
				n = start - place_start[fl][sp] - 1;   // Meter cycles between PLACE and PICKUP
				fee = tariff_rate(plate) * n;
				if (fee > 255)
					fee = 255;
			end else begin
				st = 2;
			end
		end
	endtask

	task automatic check_result(input int idx, input int start);
		logic kind;
		logic [15:0] plate;
		int st;
		int fl;
		int sp;
		int fee;
		int errors_before;
		kind = case_words[5*idx][0];
		plate = case_words[5*idx+1];
		errors_before = errors;
		model_order(kind, plate, start, st, fl, sp, fee);
		if (st != int'(case_words[5*idx+2]) || fl != int'(case_words[5*idx+3]) ||
			sp != int'(case_words[5*idx+4])) begin
			$display("Case %0d: data file expects status %0d floor %0d spot %0d",
				idx, case_words[5*idx+2], case_words[5*idx+3], case_words[5*idx+4]);
			$display("Case %0d: model gives status %0d floor %0d spot %0d", idx, st, fl, sp);
			errors++;
		end
		if (result_plate !== plate_t'(plate))
			report_mismatch("result_plate", 32'(plate), 32'(result_plate));
		if (result_status !== result_status_e'(st))
			report_mismatch("result_status", 32'(st), 32'(result_status));
		if (result_floor !== floor_t'(fl))
			report_mismatch("result_floor", 32'(fl), 32'(result_floor));
		if (result_spot !== spot_t'(sp))
			report_mismatch("result_spot", 32'(sp), 32'(result_spot));
		if (result_fee !== fee_t'(fee))
			report_mismatch("result_fee", 32'(fee), 32'(result_fee));
		if (errors == errors_before)
			passed++;
		else
			failed++;
		$display("Case %0d %s plate %h: status %0d floor %0d spot %0d fee %0d %s", idx,
			kind ? "retrieve" : "park", plate, st, fl, sp, fee,
			(errors == errors_before) ? "ok" : "FAILED");
	endtask

	// Random result_ready stalls, one check per accepted result
	task automatic collect_results();
		int seen;
		int report_start;
		logic in_report;
		seen = 0;
		report_start = 0;
		in_report = 1'b0;
		while (seen < num_cases) begin
			@(negedge clock);
			if (result_valid && !in_report) begin
				in_report = 1'b1;
				report_start = cycle_count;
			end
			lcg_state = lcg_next(lcg_state);
			result_ready = (lcg_state[17:16] != 2'b00);
			if (result_valid && result_ready) begin
				check_result(seen, report_start);
				seen++;
				in_report = 1'b0;
			end
		end
		repeat (JOB_CYCLES) begin
			@(negedge clock);
			if (result_valid) begin
				$display("Result left over after the last order at %0t ns", $time);
				errors++;
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		order_valid = 1'b0;
		order_kind = PARK;
		order_plate = '0;
		result_ready = 1'b0;
		for (int i = 0; i < 5 * MAX_CASES; i++)
			case_words[i] = 16'hFFFF;
		for (int f = 1; f <= FLOORS; f++) begin
			for (int s = 0; s < 2; s++) begin
				lot[f][s] = 16'h0;
				place_start[f][s] = 0;
			end
		end
		$readmemh("bench/parking_cases.txt", case_words);
		while (num_cases < MAX_CASES && case_words[5*num_cases] != 16'hFFFF)
			num_cases++;
		if (num_cases == 0) begin
			$display("No cases found in bench/parking_cases.txt");
			errors++;
		end
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		fork
			begin
				for (int i = 0; i < num_cases; i++)
					send_order(case_words[5*i][0], case_words[5*i+1]);
			end
			collect_results();
		join
		$display("Cases %0d, passed %0d, failed %0d, errors %0d", num_cases, passed, failed,
			errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// Watchdog sized from the number of cases
	initial begin
		int timeout_ns;
		wait (loaded);
		timeout_ns = (RESET_CYCLES + num_cases * (JOB_CYCLES + STALL_CYCLES) +
			2 * JOB_CYCLES + 20) * PERIOD;
		#(timeout_ns);
		$display("Timeout after %0d ns, results stopped arriving", timeout_ns);
		$display("Test failed");
		$finish;
	end

endmodule

// ==== source/parking_lot_top.sv ====
/* Car park top level */
`timescale 1ns/1ps

module parking_lot_top #(
	parameter int floors = parking_pkg::FLOORS_DEFAULT,
	parameter int queue_depth = parking_pkg::QUEUE_DEPTH_DEFAULT
) (
	input logic clock,
	input logic reset,
	input logic order_valid,
	output logic order_ready,
	input parking_pkg::order_kind_e order_kind,
	input parking_pkg::plate_t order_plate,
	output logic result_valid,
	input logic result_ready,
	output parking_pkg::result_status_e result_status,
	output parking_pkg::plate_t result_plate,
	output parking_pkg::floor_t result_floor,
	output parking_pkg::spot_t result_spot,
	output parking_pkg::fee_t result_fee
);

	order_if intake_to_queue ();
	order_if queue_to_elevator ();

	order_intake u_intake (
		.clock(clock),
		.reset(reset),
		.order_valid(order_valid),
		.order_ready(order_ready),
		.order_kind(order_kind),
		.order_plate(order_plate),
		.out(intake_to_queue.source)
	);

	order_fifo #(.queue_depth(queue_depth)) u_queue (
		.clock(clock),
		.reset(reset),
		.in(intake_to_queue.sink),
		.out(queue_to_elevator.source)
	);

	elevator_controller #(.floors(floors)) u_elevator (
		.clock(clock),
		.reset(reset),
		.orders(queue_to_elevator.sink),
		.result_valid(result_valid),
		.result_ready(result_ready),
		.result_status(result_status),
		.result_plate(result_plate),
		.result_floor(result_floor),
		.result_spot(result_spot),
		.result_fee(result_fee)
	);

endmodule

// ==== source/elevator_controller.sv ====
/* Elevator job controller */
`timescale 1ns/1ps

module elevator_controller #(
	parameter int floors = parking_pkg::FLOORS_DEFAULT
) (
	input logic clock,
	input logic reset,
	order_if.sink orders,
	output logic result_valid,
	input logic result_ready,
	output parking_pkg::result_status_e result_status,
	output parking_pkg::plate_t result_plate,
	output parking_pkg::floor_t result_floor,
	output parking_pkg::spot_t result_spot,
	output parking_pkg::fee_t result_fee
);
	import parking_pkg::*;

	elevator_state_e state;
	floor_t current_floor;
	order_kind_e job_kind;
	plate_t job_plate;
	body_e job_body;
	tariff_e job_tariff;
	floor_t target_floor;
	spot_t target_spot;
	result_status_e status;
	fee_t fee_q;   // Fee captured at pickup

	logic free_found;
	floor_t free_floor;
	spot_t free_spot;
	logic match_found;
	floor_t match_floor;
	spot_t match_spot;
	fee_t fee;
	logic placing;
	logic picking;

	assign orders.ready = (state == IDLE);
	assign placing = (state == PLACE);
	assign picking = (state == PICKUP);

	spot_allocator #(.floors(floors)) u_spots (
		.clock(clock),
		.reset(reset),
		.body(job_body),
		.plate(job_plate),
		.free_found(free_found),
		.free_floor(free_floor),
		.free_spot(free_spot),
		.match_found(match_found),
		.match_floor(match_floor),
		.match_spot(match_spot),
		.write_enable(placing || picking),
		.write_floor(target_floor),
		.write_spot(target_spot),
		.write_plate(placing ? job_plate : '0)
	);

	fee_meters #(.floors(floors)) u_fees (
		.clock(clock),
		.reset(reset),
		.start(placing),
		.stop(picking),
		.floor(target_floor),
		.spot(target_spot),
		.tariff(job_tariff),
		.fee(fee)
	);

	always_ff @(posedge clock) begin
		if (orders.valid && orders.ready) begin
			job_kind <= orders.kind;
			job_plate <= orders.plate;
			job_body <= orders.body;
			job_tariff <= orders.tariff;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= IDLE;
			current_floor <= '0;
			target_floor <= '0;
			target_spot <= '0;
			status <= DONE;
			fee_q <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (orders.valid) begin
						target_floor <= '0;
						target_spot <= '0;
						fee_q <= '0;
						state <= LOOKUP;
					end
				end
				LOOKUP: begin
					status <= DONE;
					if (job_kind == PARK && free_found) begin
						target_floor <= free_floor;
						target_spot <= free_spot;
						state <= ASCEND;
					end else if (job_kind == RETRIEVE && match_found) begin
						target_floor <= match_floor;
						target_spot <= match_spot;
						state <= ASCEND;
					end else begin
						status <= (job_kind == PARK) ? FULL : MISSING;   // No trip
						state <= REPORT;
					end
				end
				ASCEND: begin
					current_floor <= current_floor + 1'b1;
					if (current_floor + 1'b1 == target_floor)
						state <= (job_kind == PARK) ? PLACE : PICKUP;
				end
				PLACE: state <= DESCEND;
				PICKUP: begin
					fee_q <= fee;
					state <= DESCEND;
				end
				DESCEND: begin
					current_floor <= current_floor - 1'b1;
					if (current_floor == floor_t'(1))
						state <= REPORT;
				end
				REPORT: begin
					if (result_ready)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign result_valid = (state == REPORT);
	assign result_status = status;
	assign result_plate = job_plate;
	assign result_floor = target_floor;
	assign result_spot = target_spot;
	assign result_fee = fee_q;

	floor_in_range: assert property (@(posedge clock) disable iff (reset)
		current_floor <= floor_t'(floors));

endmodule

// ==== source/fee_meters.sv ====
/* Per-spot fee meters */
`timescale 1ns/1ps

module fee_meters #(
	parameter int floors = parking_pkg::FLOORS_DEFAULT
) (
	input logic clock,
	input logic reset,
	input logic start,
	input logic stop,
	input parking_pkg::floor_t floor,
	input parking_pkg::spot_t spot,
	input parking_pkg::tariff_e tariff,
	output parking_pkg::fee_t fee
);
	import parking_pkg::*;

	fee_t count [floors][2];       // Cycles parked, saturating
	logic occupied [floors][2];
	tariff_e rate_class [floors][2];
	floor_t row;
	fee_t count_sel;

	assign row = (floor == '0) ? '0 : floor - 1'b1;   // Entrance has no meters

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int f = 0; f < floors; f++) begin
				for (int s = 0; s < 2; s++) begin
					count[f][s] <= '0;
					occupied[f][s] <= 1'b0;
				end
			end
		end else begin
			for (int f = 0; f < floors; f++) begin
				for (int s = 0; s < 2; s++) begin
					if (start && row == floor_t'(f) && spot == spot_t'(s)) begin
						count[f][s] <= '0;
						occupied[f][s] <= 1'b1;
					end else if (stop && row == floor_t'(f) && spot == spot_t'(s)) begin
						occupied[f][s] <= 1'b0;   // Count freezes at pickup
					end else if (occupied[f][s] && count[f][s] != 8'hFF) begin
						count[f][s] <= count[f][s] + 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (start)
			rate_class[row][spot] <= tariff;
	end

	assign count_sel = count[row][spot];

	always_comb begin
		case (rate_class[row][spot])
			EXEMPT: fee = '0;
			HYBRID: fee = count_sel;
			default: fee = count_sel[7] ? 8'hFF : {count_sel[6:0], 1'b0};   // Double rate
		endcase
	end

endmodule

// ==== source/spot_allocator.sv ====
/* Spot table and search */
`timescale 1ns/1ps

module spot_allocator #(
	parameter int floors = parking_pkg::FLOORS_DEFAULT
) (
	input logic clock,
	input logic reset,
	input parking_pkg::body_e body,
	input parking_pkg::plate_t plate,
	output logic free_found,
	output parking_pkg::floor_t free_floor,
	output parking_pkg::spot_t free_spot,
	output logic match_found,
	output parking_pkg::floor_t match_floor,
	output parking_pkg::spot_t match_spot,
	input logic write_enable,
	input parking_pkg::floor_t write_floor,
	input parking_pkg::spot_t write_spot,
	input parking_pkg::plate_t write_plate
);
	import parking_pkg::*;

	plate_t spots [floors][2];   // Row 0 is floor 1
	logic even_free;
	logic [floors:1] allowed;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int f = 0; f < floors; f++) begin
				spots[f][0] <= '0;
				spots[f][1] <= '0;
			end
		end else if (write_enable) begin
			spots[write_floor - 1'b1][write_spot] <= write_plate;   // Plate 0 frees the spot
		end
	end

	// SUVs on odd floors, sedans on even floors until those are full
	always_comb begin
		even_free = 1'b0;
		for (int f = 2; f <= floors; f += 2) begin
			if (spots[f-1][0] == '0 || spots[f-1][1] == '0)
				even_free = 1'b1;
		end
		for (int f = 1; f <= floors; f++) begin
			if (f % 2 == 1)
				allowed[f] = (body == SUV) || !even_free;
			else
				allowed[f] = (body == SEDAN);
		end
	end

	// Lowest allowed floor first, left before right
	always_comb begin
		free_found = 1'b0;
		free_floor = '0;
		free_spot = '0;
		for (int f = 1; f <= floors; f++) begin
			for (int s = 0; s < 2; s++) begin
				if (!free_found && allowed[f] && spots[f-1][s] == '0) begin
					free_found = 1'b1;
					free_floor = floor_t'(f);
					free_spot = spot_t'(s);
				end
			end
		end
	end

	always_comb begin
		match_found = 1'b0;
		match_floor = '0;
		match_spot = '0;
		for (int f = 1; f <= floors; f++) begin
			for (int s = 0; s < 2; s++) begin
				if (!match_found && plate != '0 && spots[f-1][s] == plate) begin
					match_found = 1'b1;
					match_floor = floor_t'(f);
					match_spot = spot_t'(s);
				end
			end
		end
	end

endmodule

// ==== source/order_fifo.sv ====
/* Decoded order queue */
`timescale 1ns/1ps

module order_fifo #(
	parameter int queue_depth = parking_pkg::QUEUE_DEPTH_DEFAULT
) (
	input logic clock,
	input logic reset,
	order_if.sink in,
	order_if.source out
);
	import parking_pkg::*;

	localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
	localparam int cnt_w = $clog2(queue_depth + 1);
	localparam logic [ptr_w-1:0] last_slot = ptr_w'(queue_depth - 1);
	localparam logic [cnt_w-1:0] full_count = cnt_w'(queue_depth);

	order_kind_e kind_mem [queue_depth];
	plate_t plate_mem [queue_depth];
	body_e body_mem [queue_depth];
	tariff_e tariff_mem [queue_depth];

	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;   // Orders held
	logic push;
	logic pop;

	assign in.ready = (count != full_count);
	assign push = in.valid && in.ready;
	assign out.valid = (count != '0);
	assign pop = out.valid && out.ready;

	// Head entry straight from storage
	assign out.kind = kind_mem[rd_ptr];
	assign out.plate = plate_mem[rd_ptr];
	assign out.body = body_mem[rd_ptr];
	assign out.tariff = tariff_mem[rd_ptr];

	always_ff @(posedge clock) begin
		if (push) begin
			kind_mem[wr_ptr] <= in.kind;
			plate_mem[wr_ptr] <= in.plate;
			body_mem[wr_ptr] <= in.body;
			tariff_mem[wr_ptr] <= in.tariff;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == last_slot) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == last_slot) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	no_write_when_full: assert property (@(posedge clock) disable iff (reset)
		count == full_count && !pop |=> count == full_count && wr_ptr == $past(wr_ptr));

	no_read_when_empty: assert property (@(posedge clock) disable iff (reset)
		count == '0 && !push |=> count == '0 && rd_ptr == $past(rd_ptr));

endmodule

// ==== source/order_intake.sv ====
/* Order intake stage */
`timescale 1ns/1ps

module order_intake (
	input logic clock,
	input logic reset,
	input logic order_valid,
	output logic order_ready,
	input parking_pkg::order_kind_e order_kind,
	input parking_pkg::plate_t order_plate,
	order_if.source out
);
	import parking_pkg::*;

	logic started;   // Set on the first clock after reset
	logic held;      // Stage holds an order
	logic load;
	order_kind_e kind_q;
	plate_t plate_q;

	assign order_ready = started && (!held || out.ready);
	assign load = order_valid && order_ready;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			started <= 1'b0;
			held <= 1'b0;
		end else begin
			started <= 1'b1;
			if (load)
				held <= 1'b1;
			else if (out.ready)
				held <= 1'b0;   // Drained into the queue
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			kind_q <= order_kind;
			plate_q <= order_plate;
		end
	end

	assign out.valid = held;
	assign out.kind = kind_q;
	assign out.plate = plate_q;
	assign out.body = plate_q[0] ? SUV : SEDAN;   // Odd plates are SUVs
	assign out.tariff = (plate_q[15:12] == EXEMPT_NIBBLE) ? EXEMPT :
		(plate_q[15:12] == HYBRID_NIBBLE) ? HYBRID : REGULAR;

	// A stalled order keeps its payload until the queue takes it
	stall_holds_payload: assert property (@(posedge clock) disable iff (reset)
		out.valid && !out.ready |=> out.valid && $stable(out.plate) && $stable(out.kind));

endmodule

// ==== source/order_if.sv ====
/* Decoded order channel */
`timescale 1ns/1ps

interface order_if;
	import parking_pkg::*;

	logic valid;
	logic ready;
	order_kind_e kind;
	plate_t plate;
	body_e body;
	tariff_e tariff;

	// Producer side
	modport source (output valid, output kind, output plate, output body, output tariff,
		input ready);

	// Consumer side
	modport sink (input valid, input kind, input plate, input body, input tariff,
		output ready);

endinterface

// ==== source/parking_pkg.sv ====
/* Car park shared definitions */
package parking_pkg;

	// Default sizes, overridden from the top level
	localparam int FLOORS_DEFAULT = 7;
	localparam int QUEUE_DEPTH_DEFAULT = 8;

	// Plate top nibble codes for the tariff classes
	localparam logic [3:0] EXEMPT_NIBBLE = 4'h9;
	localparam logic [3:0] HYBRID_NIBBLE = 4'h8;

	typedef logic [15:0] plate_t;   // Zero means no car
	typedef logic [2:0] floor_t;    // Floor 0 is the entrance
	typedef logic spot_t;           // 0 left, 1 right
	typedef logic [7:0] fee_t;

	typedef enum logic {PARK, RETRIEVE} order_kind_e;

	typedef enum logic [1:0] {EXEMPT, HYBRID, REGULAR} tariff_e;

	typedef enum logic {SEDAN, SUV} body_e;

	typedef enum logic [1:0] {DONE, FULL, MISSING} result_status_e;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		ASCEND,
		PLACE,
		PICKUP,
		DESCEND,
		REPORT
	} elevator_state_e;

endpackage
